// File: sb_pkg.sv
// System-bus definitions shared by the bus-to-FIFO bridge and its queue
`default_nettype none

package sb_pkg;

    // Default data-word width of the bus, not counting the two tag bits
    localparam int sb_width = 64;

    // Beat tag, carried in the top two bits of every bus beat
    typedef logic [1:0] sb_tag_t;

    // Tag codes on the master channel (requests toward the slave)
    localparam sb_tag_t sb_m_rd_hdr  = 2'b00;
    localparam sb_tag_t sb_m_wr_hdr  = 2'b01;
    localparam sb_tag_t sb_m_wr_data = 2'b10;
    localparam sb_tag_t sb_m_wr_last = 2'b11;

    // Tag codes on the slave channel (responses back to the master)
    localparam sb_tag_t sb_s_wr_rsp  = 2'b00;
    localparam sb_tag_t sb_s_rd_hdr  = 2'b01;
    localparam sb_tag_t sb_s_rd_data = 2'b10;
    localparam sb_tag_t sb_s_rd_last = 2'b11;

    // Header field positions; address sits at the bottom, below the length
    localparam int sb_len_lo = 32;
    localparam int sb_len_w  = 4;
    localparam int sb_id_lo  = 41;

    // The byte mask takes one bit per byte at the top of the word
    function automatic int sb_mask_width(input int bwidth);
        return bwidth / 8;
    endfunction

    // The id runs from bit 41 up to just below the byte mask
    function automatic int sb_id_width(input int bwidth);
        return bwidth - sb_mask_width(bwidth) - sb_id_lo;
    endfunction

    // Header view of a bus word, most significant field first
    typedef struct packed {
        logic [sb_mask_width(sb_width)-1:0]      mask;
        logic [sb_id_width(sb_width)-1:0]        id;
        logic [sb_id_lo-sb_len_lo-sb_len_w-1:0] rsvd;
        logic [sb_len_w-1:0]                     len;
        logic [sb_len_lo-1:0]                    addr;
    } sb_hdr_t;

    // One bus word seen either as plain data or as a request/response header
    typedef union packed {
        logic [sb_width-1:0] raw;
        sb_hdr_t             hdr;
    } sb_word_u;

endpackage

`default_nettype wire

// File: word_fifo.sv
// Single-clock word FIFO with not-full and not-empty levels and a combinational head word
`timescale 1ns/1ns
`default_nettype none

module word_fifo
    import sb_pkg::*;
#(
    parameter int BWIDTH = sb_width,
    parameter int DEPTH  = 16
) (
    input  logic              CLK,
    input  logic              RST,

    // Push side
    input  logic              wr,
    input  logic [BWIDTH-1:0] wr_data,
    output logic              wr_rdy,

    // Pop side
    input  logic              rd,
    output logic [BWIDTH-1:0] rd_data,
    output logic              rd_rdy
);

    // Pointer and occupancy widths; the count must reach DEPTH itself
    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    localparam logic [AW-1:0] last_ptr = AW'(DEPTH - 1);
    localparam logic [CW-1:0] full_cnt = CW'(DEPTH);

    // Storage array
    logic [BWIDTH-1:0] mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;

    logic push;
    logic pop;

    // Strobes beyond the levels are dropped here and flagged below
    assign push = wr && wr_rdy;
    assign pop  = rd && rd_rdy;

    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // A push and pop together leave the count as it is
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            count <= '0;
        end else if (push && !pop) begin
            count <= count + 1'b1;
        end else if (pop && !push) begin
            count <= count - 1'b1;
        end
    end

    assign wr_rdy  = (count != full_cnt);
    assign rd_rdy  = (count != '0);

    // Head word; a word pushed into an empty queue shows up after the edge
    assign rd_data = mem[rd_ptr];

    a_no_push_full: assert property (@(posedge CLK) disable iff (RST)
        wr |-> count < full_cnt)
        else $error("word_fifo: push while full");

    a_no_pop_empty: assert property (@(posedge CLK) disable iff (RST)
        rd |-> count > '0)
        else $error("word_fifo: pop while empty");

endmodule

`default_nettype wire

// File: sb_fifo_bridge.sv
// Split-transaction bus slave port that turns bus requests into FIFO push and pop strobes
`timescale 1ns/1ns
`default_nettype none

module sb_fifo_bridge
    import sb_pkg::*;
#(
    parameter int BWIDTH = sb_width
) (
    input  logic              CLK,
    input  logic              RST,

    // Master channel, requests coming in
    input  logic [BWIDTH+1:0] sp_m_bus,
    input  logic              sp_m_vld,
    output logic              sp_m_rdy,

    // Slave channel, responses going out
    output logic [BWIDTH+1:0] sp_s_bus,
    output logic              sp_s_vld,
    input  logic              sp_s_rdy,

    // Queue read side
    input  logic              rd_rdy,
    output logic              rd,
    input  logic [BWIDTH-1:0] rd_data,

    // Queue write side
    input  logic              wr_rdy,
    output logic              wr,
    output logic [BWIDTH-1:0] wr_data
);

    // The header union is laid out for a 64-bit word only
    if (BWIDTH != sb_width) begin : g_width_chk
        $error("sb_fifo_bridge: header layout needs BWIDTH of %0d", sb_width);
    end

    // Incoming beat split into its tag and its word
    sb_tag_t  m_tag;
    sb_word_u m_word;

    // Outgoing beat before it is joined onto the slave bus
    sb_tag_t  s_tag;
    sb_word_u s_word;

    // Write side state
    logic                             wr_resp_pend;
    logic [sb_id_width(BWIDTH)-1:0]   wr_id;
    logic                             wr_hdr;
    logic                             wr_beat;
    logic                             wr_last;

    // Read side state
    logic       rd_active;
    logic [3:0] rd_cnt;
    logic       rd_req;
    logic       rd_accept;
    logic       rd_last;
    logic       rd_done;

    assign m_tag  = sp_m_bus[BWIDTH+1:BWIDTH];
    assign m_word = sp_m_bus[BWIDTH-1:0];

    // A write header is only taken once the previous write response is gone,
    // since there is a single id register to echo
    assign wr_hdr  = sp_m_vld && (m_tag == sb_m_wr_hdr) && !wr_resp_pend;

    // Data and last data beats both go straight into the queue
    assign wr_beat = sp_m_vld && ((m_tag == sb_m_wr_data) || (m_tag == sb_m_wr_last));
    assign wr_last = wr_beat && wr_rdy && (m_tag == sb_m_wr_last);

    // Id of the write burst in progress, echoed in its response
    always_ff @(posedge CLK) begin
        if (wr_hdr) begin
            wr_id <= m_word.hdr.id;
        end
    end

    // The response is due from the cycle after the last beat and stays due
    // until the slave channel takes it; an active read keeps the bus first
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            wr_resp_pend <= 1'b0;
        end else begin
            wr_resp_pend <= wr_last || (wr_resp_pend && !(sp_s_rdy && !rd_active));
        end
    end

    // Only one read may be open, and it must not overtake a pending response
    assign rd_req    = sp_m_vld && (m_tag == sb_m_rd_hdr) && !rd_active && !wr_resp_pend;

    // The response header goes out combinationally, so the request is taken
    // only when the receiver can take that header in the same cycle
    assign rd_accept = rd_req && sp_s_rdy;

    // Pop only when a word is there and the receiver takes it
    assign rd        = rd_active && sp_s_rdy && rd_rdy;

    // The final word is marked from the count alone so the tag does not
    // change while the receiver stalls
    assign rd_last   = rd_active && (rd_cnt == 4'd0);
    assign rd_done   = rd && (rd_cnt == 4'd0);

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            rd_active <= 1'b0;
        end else if (rd_accept) begin
            rd_active <= 1'b1;
        end else if (rd_done) begin
            rd_active <= 1'b0;
        end
    end

    // Counts the words still to send after the current head, n down to zero
    always_ff @(posedge CLK) begin
        if (rd_accept) begin
            rd_cnt <= m_word.hdr.len;
        end else if (rd) begin
            rd_cnt <= rd_cnt - 4'd1;
        end
    end

    assign wr      = wr_beat && wr_rdy;
    assign wr_data = m_word.raw;

    // Read data goes out first, then a new read header, and otherwise the
    // write response
    always_comb begin
        s_word = '0;
        s_tag  = sb_s_wr_rsp;
        if (rd_active) begin
            s_word.raw = rd_data;
            s_tag      = rd_last ? sb_s_rd_last : sb_s_rd_data;
        end else if (rd_req) begin
            s_word.hdr.id = m_word.hdr.id;
            s_tag         = sb_s_rd_hdr;
        end else begin
            s_word.hdr.id = wr_id;
        end
    end

    assign sp_s_bus = {s_tag, s_word.raw};

    // During a read the bus carries only queue words, so a pending write
    // response must not show valid over an empty queue
    assign sp_s_vld = rd_active ? rd_rdy : (wr_resp_pend || rd_req);

    assign sp_m_rdy = wr_hdr || (wr_beat && wr_rdy) || rd_accept;

    // A beat offered to a stalled receiver stays put until it is taken
    a_s_bus_stable: assert property (@(posedge CLK) disable iff (RST)
        sp_s_vld && !sp_s_rdy |=> sp_s_vld && $stable(sp_s_bus))
        else $error("sb_fifo_bridge: slave beat changed while stalled");

endmodule

`default_nettype wire

// File: sb_fifo_top.sv
// Top level joining the bus-to-FIFO bridge to its word queue
`timescale 1ns/1ns
`default_nettype none

module sb_fifo_top
    import sb_pkg::*;
#(
    parameter int BWIDTH = sb_width,
    parameter int DEPTH  = 16
) (
    input  logic              CLK,
    input  logic              RST,

    // Master channel
    input  logic [BWIDTH+1:0] sp_m_bus,
    input  logic              sp_m_vld,
    output logic              sp_m_rdy,

    // Slave channel
    output logic [BWIDTH+1:0] sp_s_bus,
    output logic              sp_s_vld,
    input  logic              sp_s_rdy
);

    // Queue strobes and levels between the bridge and the queue
    logic              rd_rdy;
    logic              rd;
    logic [BWIDTH-1:0] rd_data;
    logic              wr_rdy;
    logic              wr;
    logic [BWIDTH-1:0] wr_data;

    sb_fifo_bridge #(
        .BWIDTH (BWIDTH)
    ) bridge0 (
        .CLK      (CLK),
        .RST      (RST),
        .sp_m_bus (sp_m_bus),
        .sp_m_vld (sp_m_vld),
        .sp_m_rdy (sp_m_rdy),
        .sp_s_bus (sp_s_bus),
        .sp_s_vld (sp_s_vld),
        .sp_s_rdy (sp_s_rdy),
        .rd_rdy   (rd_rdy),
        .rd       (rd),
        .rd_data  (rd_data),
        .wr_rdy   (wr_rdy),
        .wr       (wr),
        .wr_data  (wr_data)
    );

    word_fifo #(
        .BWIDTH (BWIDTH),
        .DEPTH  (DEPTH)
    ) fifo0 (
        .CLK     (CLK),
        .RST     (RST),
        .wr      (wr),
        .wr_data (wr_data),
        .wr_rdy  (wr_rdy),
        .rd      (rd),
        .rd_data (rd_data),
        .rd_rdy  (rd_rdy)
    );

endmodule

`default_nettype wire

// File: tb_sb_fifo.sv
// Self-checking testbench for the bus-to-FIFO bridge against a reference queue model
`timescale 1ns/1ns
`default_nettype none

module tb_sb_fifo;
    import sb_pkg::*;

    localparam int BWIDTH = sb_width;
    localparam int DEPTH  = 16;
    localparam int IDW    = sb_id_width(BWIDTH);

    localparam logic [31:0] SEED = 32'h5c31d617;

    logic              CLK;
    logic              RST;
    logic [BWIDTH+1:0] sp_m_bus;
    logic              sp_m_vld;
    logic              sp_m_rdy;
    logic [BWIDTH+1:0] sp_s_bus;
    logic              sp_s_vld;
    logic              sp_s_rdy;

    // Reference model of the queue contents and of the write responses still due
    logic [BWIDTH-1:0] model_q [$];
    logic [IDW-1:0]    wr_id_q [$];

    // Model view of the slave channel, kept by the monitor only
    logic              in_read = 1'b0;
    logic [3:0]        rd_left = '0;
    logic [IDW-1:0]    cur_wr_id = '0;

    // Beat counts on both channels set the timeout limit
    int unsigned m_beats = 0;
    int unsigned s_beats = 0;
    int unsigned cycle_cnt = 0;

    // Receiver is held stalled up to this cycle, then stalls at random
    int unsigned hold_until = 0;

    // Words written but not yet asked for by a read request
    int unclaimed = 0;

    sb_fifo_top #(
        .BWIDTH (BWIDTH),
        .DEPTH  (DEPTH)
    ) dut0 (
        .CLK      (CLK),
        .RST      (RST),
        .sp_m_bus (sp_m_bus),
        .sp_m_vld (sp_m_vld),
        .sp_m_rdy (sp_m_rdy),
        .sp_s_bus (sp_s_bus),
        .sp_s_vld (sp_s_vld),
        .sp_s_rdy (sp_s_rdy)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    task automatic report_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        $display("test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    // A hang stops the beat counts, so the cycle count overtakes the limit
    always @(posedge CLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > 20 * (m_beats + s_beats + 8)) begin
            $display("Timeout: the bus stopped moving after %0d clock cycles", cycle_cnt);
            $display("test failed");
            $fatal(1, "simulation stopped on timeout");
        end
    end

    // Receiver ready, changed on the falling edge only
    initial begin
        sp_s_rdy = 1'b0;
        forever begin
            @(negedge CLK);
            if (cycle_cnt < hold_until) begin
                sp_s_rdy = 1'b0;
            end else begin
                sp_s_rdy = ($urandom % 4) != 0;
            end
        end
    end

    // A stalled receiver must see the same beat again on the next edge
    a_hold_while_stalled: assert property (@(posedge CLK) disable iff (RST)
        sp_s_vld && !sp_s_rdy |=> sp_s_vld && $stable(sp_s_bus))
        else report_error("slave beat changed while the receiver stalled");

    // Offers one beat and holds it until the bridge raises ready
    task automatic send_beat(input sb_tag_t tag, input logic [BWIDTH-1:0] word);
        @(negedge CLK);
        sp_m_bus = {tag, word};
        sp_m_vld = 1'b1;
        #1;
        while (!sp_m_rdy) begin
            @(negedge CLK);
            #1;
        end
    endtask

    task automatic release_bus();
        @(negedge CLK);
        sp_m_vld = 1'b0;
    endtask

    // Header with a random id, address and mask, then len data words
    task automatic write_burst(input int len);
        sb_word_u w;
        int       i;
        w.raw = {$urandom, $urandom};
        send_beat(sb_m_wr_hdr, w.raw);
        for (i = 0; i < len; i++) begin
            // An idle cycle now and then inside the burst
            if ($urandom % 4 == 0) begin
                release_bus();
            end
            w.raw = {$urandom, $urandom};
            send_beat((i == len - 1) ? sb_m_wr_last : sb_m_wr_data, w.raw);
        end
        release_bus();
        unclaimed += len;
    endtask

    // Asks for a number of words, sent as length n = words - 1
    task automatic read_request(input int words);
        sb_word_u w;
        w.raw = {$urandom, $urandom};
        w.hdr.len = 4'(words - 1);
        send_beat(sb_m_rd_hdr, w.raw);
        release_bus();
        unclaimed -= words;
    endtask

    // Monitor; looks after the falling-edge drive, where both channels are settled
    initial begin
        sb_tag_t  s_tag;
        sb_tag_t  m_tag;
        sb_tag_t  exp_tag;
        sb_word_u s_word;
        sb_word_u m_word;
        logic     rd_offer;
        forever begin
            @(negedge CLK);
            #2;
            if (!RST) begin
                s_tag    = sp_s_bus[BWIDTH+1:BWIDTH];
                s_word   = sp_s_bus[BWIDTH-1:0];
                m_tag    = sp_m_bus[BWIDTH+1:BWIDTH];
                m_word   = sp_m_bus[BWIDTH-1:0];
                rd_offer = sp_m_vld && (m_tag == sb_m_rd_hdr);

                // Slave beat against what is due: read data, a new read header
                // or the oldest write response
                if (sp_s_vld) begin
                    if (in_read) begin
                        exp_tag = (rd_left == 4'd0) ? sb_s_rd_last : sb_s_rd_data;
                        assert (s_tag == exp_tag)
                            else report_error($sformatf("read data tag %b, expected %b",
                                                        s_tag, exp_tag));
                        assert (model_q.size() != 0)
                            else report_error("read data beat with no word in the model");
                        assert (s_word.raw == model_q[0])
                            else report_error($sformatf("read data %h, expected %h",
                                                        s_word.raw, model_q[0]));
                    end else if (rd_offer && wr_id_q.size() == 0) begin
                        assert (s_tag == sb_s_rd_hdr && s_word.hdr.id == m_word.hdr.id)
                            else report_error($sformatf("read header tag %b id %h, expected id %h",
                                                        s_tag, s_word.hdr.id, m_word.hdr.id));
                    end else if (wr_id_q.size() != 0) begin
                        assert (s_tag == sb_s_wr_rsp && s_word.hdr.id == wr_id_q[0])
                            else report_error($sformatf("write response tag %b id %h, expected id %h",
                                                        s_tag, s_word.hdr.id, wr_id_q[0]));
                    end else begin
                        report_error($sformatf("slave beat tag %b with no response due", s_tag));
                    end
                end

                // Data beats stall exactly when the model queue holds DEPTH words
                if (sp_m_vld && (m_tag == sb_m_wr_data || m_tag == sb_m_wr_last)) begin
                    assert (sp_m_rdy == (model_q.size() < DEPTH))
                        else report_error($sformatf("data beat ready %b with %0d words queued",
                                                    sp_m_rdy, model_q.size()));
                end

                // A write header waits while a write response is still due
                if (sp_m_vld && m_tag == sb_m_wr_hdr) begin
                    assert (sp_m_rdy == (wr_id_q.size() == 0))
                        else report_error($sformatf("write header ready %b with %0d responses due",
                                                    sp_m_rdy, wr_id_q.size()));
                end

                // Model update for the beats that move on the coming edge
                if (sp_s_vld && sp_s_rdy) begin
                    s_beats++;
                    if (in_read) begin
                        void'(model_q.pop_front());
                        if (rd_left == 4'd0) begin
                            in_read = 1'b0;
                        end else begin
                            rd_left = rd_left - 4'd1;
                        end
                    end else if (rd_offer && wr_id_q.size() == 0) begin
                        in_read = 1'b1;
                        rd_left = m_word.hdr.len;
                    end else begin
                        void'(wr_id_q.pop_front());
                    end
                end
                if (sp_m_vld && sp_m_rdy) begin
                    m_beats++;
                    case (m_tag)
                        sb_m_wr_hdr: cur_wr_id = m_word.hdr.id;
                        sb_m_wr_data: model_q.push_back(m_word.raw);
                        sb_m_wr_last: begin
                            model_q.push_back(m_word.raw);
                            wr_id_q.push_back(cur_wr_id);
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    initial begin
        int i;
        int len;
        int n;
        void'($urandom(SEED));
        RST      = 1'b1;
        sp_m_bus = '0;
        sp_m_vld = 1'b0;
        repeat (5) @(negedge CLK);
        RST = 1'b0;

        // Read issued on an empty queue waits for the burst that follows
        read_request(6);
        write_burst(6);

        // Receiver held off while more than DEPTH words go in, then drained
        read_request(DEPTH);
        hold_until = cycle_cnt + 60;
        write_burst(DEPTH + 3);
        read_request(3);

        // Random bursts, each followed by a read of some of the words written so far
        for (i = 0; i < 24; i++) begin
            len = 1 + $urandom % 8;
            if (len > DEPTH - unclaimed) begin
                len = DEPTH - unclaimed;
            end
            if (len > 0) begin
                write_burst(len);
            end
            n = 1 + $urandom % ((unclaimed < 16) ? unclaimed : 16);
            read_request(n);
        end

        // Read back whatever is left, then wait for the last responses
        while (unclaimed > 0) begin
            read_request((unclaimed < 16) ? unclaimed : 16);
        end
        while (in_read || wr_id_q.size() != 0 || model_q.size() != 0) begin
            @(negedge CLK);
        end
        repeat (4) @(negedge CLK);

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
sb_pkg.sv
word_fifo.sv
sb_fifo_bridge.sv
sb_fifo_top.sv
tb_sb_fifo.sv

// File: Makefile
# Verilator build and run of the bus-to-FIFO bridge testbench

SRCS := $(shell cat files.f)

.PHONY: all run clean

all: run

# The simulator binary is rebuilt only when a source or the file list changes
obj_dir/Vtb_sb_fifo: files.f $(SRCS)
	verilator --binary --timing --assert -sv -f files.f --top-module tb_sb_fifo -o Vtb_sb_fifo

run: obj_dir/Vtb_sb_fifo
	-obj_dir/Vtb_sb_fifo > sim.log 2>&1
	@cat sim.log
	@if grep -q "test failed" sim.log; then echo "simulation reported a failure"; exit 1; fi
	@grep -q "test passed" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log
